// File: design/mips_isa_pkg.sv
package mips_isa_pkg;

        typedef logic [31:0] word_t;
        typedef logic [4:0]  reg_addr_t;
        typedef logic [15:0] imm_t;
        typedef logic [5:0]  opcode_t;
        typedef logic [5:0]  funct_t;
        typedef logic [2:0]  alu_op_t;

        // Major opcodes, bits 31:26 of the instruction.
        localparam opcode_t OPC_SPECIAL = 6'h00;
        localparam opcode_t OPC_BEQ     = 6'h04;
        localparam opcode_t OPC_BNE     = 6'h05;
        localparam opcode_t OPC_ADDIU   = 6'h09;
        localparam opcode_t OPC_ORI     = 6'h0d;
        localparam opcode_t OPC_LW      = 6'h23;
        localparam opcode_t OPC_SW      = 6'h2b;

        // Function codes of the SPECIAL group.
        localparam funct_t FN_ADDU = 6'h21;
        localparam funct_t FN_SUBU = 6'h23;
        localparam funct_t FN_AND  = 6'h24;
        localparam funct_t FN_OR   = 6'h25;
        localparam funct_t FN_SLT  = 6'h2a;

        localparam alu_op_t ALU_ADD = 3'd0;
        localparam alu_op_t ALU_SUB = 3'd1;
        localparam alu_op_t ALU_AND = 3'd2;
        localparam alu_op_t ALU_OR  = 3'd3;
        localparam alu_op_t ALU_SLT = 3'd4;

endpackage

// File: design/mips_pipe_pkg.sv
package mips_pipe_pkg;

        typedef logic [1:0] mem_op_t;

        localparam mem_op_t MEM_NONE  = 2'd0;
        localparam mem_op_t MEM_LOAD  = 2'd1;
        localparam mem_op_t MEM_STORE = 2'd2;

        localparam mips_isa_pkg::word_t RESET_PC = 32'h0000_0000;
        // All zeros decodes as SLL r0, r0, 0.
        localparam mips_isa_pkg::word_t NOP_WORD = 32'h0000_0000;

endpackage

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
        input  logic                    clk,
        input  logic                    rst_n,
        input  mips_isa_pkg::reg_addr_t rs_addr_i,
        input  mips_isa_pkg::reg_addr_t rt_addr_i,
        output mips_isa_pkg::word_t     rs_data_o,
        output mips_isa_pkg::word_t     rt_data_o,
        input  logic                    we_i,
        input  mips_isa_pkg::reg_addr_t waddr_i,
        input  mips_isa_pkg::word_t     wdata_i
);
        import mips_isa_pkg::*;

        word_t regs [0:31];

        // Register zero is never written, so it reads as zero after reset.
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        regs <= '{default: '0};
                end else if (we_i && waddr_i != '0) begin
                        regs[waddr_i] <= wdata_i;
                end
        end

        assign rs_data_o = regs[rs_addr_i];
        assign rt_data_o = regs[rt_addr_i];

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
        input  logic                clk,
        input  logic                rst_n,
        input  logic                en_pc_i,
        input  logic                en_ifid_i,
        input  logic                en_idex_i,
        input  logic                branch_taken_i,
        input  mips_isa_pkg::word_t branch_target_i,
        input  mips_isa_pkg::word_t ibus_rddata_i,
        output mips_isa_pkg::word_t pc_o,
        output mips_isa_pkg::word_t id_inst_o,
        output mips_isa_pkg::word_t id_pc_o
);
        import mips_pipe_pkg::*;

        // The branch sits in decode while its delay slot is fetched.
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        pc_o <= RESET_PC;
                end else if (en_pc_i) begin
                        pc_o <= branch_taken_i ? branch_target_i : pc_o + 32'd4;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        id_inst_o <= NOP_WORD;
                        id_pc_o   <= RESET_PC;
                end else if (en_ifid_i) begin
                        id_inst_o <= ibus_rddata_i;
                        id_pc_o   <= pc_o;
                end else if (en_idex_i) begin
                        // Decode moved on without a new fetch behind it.
                        id_inst_o <= NOP_WORD;
                end
        end

endmodule

// File: design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    en_idex_i,
        input  logic                    en_exmm_i,
        input  mips_isa_pkg::word_t     inst_i,
        input  mips_isa_pkg::word_t     pc_i,
        output mips_isa_pkg::reg_addr_t rs_addr_o,
        output mips_isa_pkg::reg_addr_t rt_addr_o,
        input  mips_isa_pkg::word_t     rs_data_i,
        input  mips_isa_pkg::word_t     rt_data_i,
        input  mips_isa_pkg::reg_addr_t ex_dest_i,
        input  mips_isa_pkg::reg_addr_t mm_dest_i,
        input  mips_isa_pkg::reg_addr_t wb_dest_i,
        input  mips_isa_pkg::word_t     ex_result_i,
        input  mips_isa_pkg::word_t     mm_result_i,
        input  mips_isa_pkg::word_t     wb_result_i,
        input  logic                    wb_we_i,
        output logic                    branch_taken_o,
        output mips_isa_pkg::word_t     branch_target_o,
        output mips_isa_pkg::alu_op_t   ex_alu_op_o,
        output mips_pipe_pkg::mem_op_t  ex_mem_op_o,
        output mips_isa_pkg::word_t     ex_a_o,
        output mips_isa_pkg::word_t     ex_b_o,
        output mips_isa_pkg::word_t     ex_store_data_o,
        output mips_isa_pkg::reg_addr_t ex_dest_o
);
        import mips_isa_pkg::*;
        import mips_pipe_pkg::*;

        opcode_t   opcode;
        funct_t    funct;
        imm_t      imm;
        word_t     imm_sext;
        word_t     rs_val;
        word_t     rt_val;
        word_t     operand_b;
        alu_op_t   alu_op;
        mem_op_t   mem_op;
        reg_addr_t dest;

        assign opcode    = inst_i[31:26];
        assign rs_addr_o = inst_i[25:21];
        assign rt_addr_o = inst_i[20:16];
        assign funct     = inst_i[5:0];
        assign imm       = inst_i[15:0];
        assign imm_sext  = {{16{imm[15]}}, imm};

        // The youngest producer wins. A load still in execute has no data yet.
        function automatic word_t fwd(input reg_addr_t src, input word_t rf_val);
                word_t val;
                val = rf_val;
                if (src != '0) begin
                        if (ex_dest_i == src && ex_mem_op_o != MEM_LOAD)
                                val = ex_result_i;
                        else if (mm_dest_i == src)
                                val = mm_result_i;
                        else if (wb_we_i && wb_dest_i == src)
                                val = wb_result_i;
                end
                return val;
        endfunction

        assign rs_val = fwd(rs_addr_o, rs_data_i);
        assign rt_val = fwd(rt_addr_o, rt_data_i);

        always_comb begin
                alu_op    = ALU_ADD;
                mem_op    = MEM_NONE;
                dest      = '0;
                operand_b = rt_val;
                case (opcode)
                        OPC_SPECIAL: begin
                                dest = inst_i[15:11];
                                case (funct)
                                        FN_ADDU: alu_op = ALU_ADD;
                                        FN_SUBU: alu_op = ALU_SUB;
                                        FN_AND:  alu_op = ALU_AND;
                                        FN_OR:   alu_op = ALU_OR;
                                        FN_SLT:  alu_op = ALU_SLT;
                                        default: dest = '0;
                                endcase
                        end
                        OPC_ADDIU: begin
                                dest      = rt_addr_o;
                                operand_b = imm_sext;
                        end
                        OPC_ORI: begin
                                alu_op    = ALU_OR;
                                dest      = rt_addr_o;
                                operand_b = {16'h0000, imm};
                        end
                        OPC_LW: begin
                                mem_op    = MEM_LOAD;
                                dest      = rt_addr_o;
                                operand_b = imm_sext;
                        end
                        OPC_SW: begin
                                mem_op    = MEM_STORE;
                                operand_b = imm_sext;
                        end
                        default: ;
                endcase
        end

        // The offset is relative to the delay-slot address.
        assign branch_target_o = pc_i + 32'd4 + {imm_sext[29:0], 2'b00};
        assign branch_taken_o  = (opcode == OPC_BEQ && rs_val == rt_val) ||
                                 (opcode == OPC_BNE && rs_val != rt_val);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        ex_alu_op_o     <= ALU_ADD;
                        ex_mem_op_o     <= MEM_NONE;
                        ex_dest_o       <= '0;
                        ex_a_o          <= '0;
                        ex_b_o          <= '0;
                        ex_store_data_o <= '0;
                end else if (en_idex_i) begin
                        ex_alu_op_o     <= alu_op;
                        ex_mem_op_o     <= mem_op;
                        ex_dest_o       <= dest;
                        ex_a_o          <= rs_val;
                        ex_b_o          <= operand_b;
                        ex_store_data_o <= rt_val;
                end else if (en_exmm_i) begin
                        ex_mem_op_o <= MEM_NONE;
                        ex_dest_o   <= '0;
                end
        end

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    en_exmm_i,
        input  logic                    en_mmwb_i,
        input  mips_isa_pkg::alu_op_t   alu_op_i,
        input  mips_pipe_pkg::mem_op_t  mem_op_i,
        input  mips_isa_pkg::word_t     a_i,
        input  mips_isa_pkg::word_t     b_i,
        input  mips_isa_pkg::word_t     store_data_i,
        input  mips_isa_pkg::reg_addr_t dest_i,
        output mips_isa_pkg::word_t     result_o,
        output mips_isa_pkg::word_t     mm_addr_o,
        output mips_isa_pkg::word_t     mm_store_data_o,
        output mips_pipe_pkg::mem_op_t  mm_mem_op_o,
        output mips_isa_pkg::reg_addr_t mm_dest_o
);
        import mips_isa_pkg::*;
        import mips_pipe_pkg::*;

        always_comb begin
                case (alu_op_i)
                        ALU_SUB: result_o = a_i - b_i;
                        ALU_AND: result_o = a_i & b_i;
                        ALU_OR:  result_o = a_i | b_i;
                        ALU_SLT: result_o = {31'b0, $signed(a_i) < $signed(b_i)};
                        default: result_o = a_i + b_i;
                endcase
        end

        // For loads and stores the result is the data address.
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        mm_addr_o       <= '0;
                        mm_store_data_o <= '0;
                        mm_mem_op_o     <= MEM_NONE;
                        mm_dest_o       <= '0;
                end else if (en_exmm_i) begin
                        mm_addr_o       <= result_o;
                        mm_store_data_o <= store_data_i;
                        mm_mem_op_o     <= mem_op_i;
                        mm_dest_o       <= dest_i;
                end else if (en_mmwb_i) begin
                        mm_mem_op_o <= MEM_NONE;
                        mm_dest_o   <= '0;
                end
        end

endmodule

// File: design/mem_access.sv
`timescale 1ns/1ps

module mem_access (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    en_mmwb_i,
        input  mips_isa_pkg::word_t     addr_i,
        input  mips_isa_pkg::word_t     store_data_i,
        input  mips_pipe_pkg::mem_op_t  mem_op_i,
        input  mips_isa_pkg::reg_addr_t dest_i,
        output mips_isa_pkg::word_t     mm_result_o,
        output mips_isa_pkg::word_t     dbus_addr_o,
        output logic                    dbus_read_o,
        output logic                    dbus_write_o,
        output mips_isa_pkg::word_t     dbus_wrdata_o,
        input  mips_isa_pkg::word_t     dbus_rddata_i,
        input  logic                    dbus_stall_i,
        output logic                    wb_we_o,
        output mips_isa_pkg::reg_addr_t wb_dest_o,
        output mips_isa_pkg::word_t     wb_result_o
);
        import mips_pipe_pkg::*;

        assign dbus_addr_o   = addr_i;
        assign dbus_read_o   = mem_op_i == MEM_LOAD;
        assign dbus_write_o  = mem_op_i == MEM_STORE;
        assign dbus_wrdata_o = store_data_i;

        assign mm_result_o = dbus_read_o ? dbus_rddata_i : addr_i;

        // MM/WB only loads when the bus is not stalled, so load data is final.
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wb_we_o     <= 1'b0;
                        wb_dest_o   <= '0;
                        wb_result_o <= '0;
                end else if (en_mmwb_i && !dbus_stall_i) begin
                        wb_we_o     <= mem_op_i != MEM_STORE && dest_i != '0;
                        wb_dest_o   <= dest_i;
                        wb_result_o <= mm_result_o;
                end else begin
                        wb_we_o <= 1'b0;
                end
        end

endmodule

// File: design/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl (
        input  logic                    ibus_stall_i,
        input  logic                    dbus_stall_i,
        input  mips_pipe_pkg::mem_op_t  ex_mem_op_i,
        input  mips_isa_pkg::reg_addr_t ex_dest_i,
        input  mips_isa_pkg::reg_addr_t id_rs_i,
        input  mips_isa_pkg::reg_addr_t id_rt_i,
        output logic                    en_pc_o,
        output logic                    en_ifid_o,
        output logic                    en_idex_o,
        output logic                    en_exmm_o,
        output logic                    en_mmwb_o
);
        import mips_pipe_pkg::*;

        logic load_use;

        assign load_use = ex_mem_op_i == MEM_LOAD &&
                          (ex_dest_i == id_rs_i || ex_dest_i == id_rt_i);

        always_comb begin
                if (dbus_stall_i) begin
                        {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = 5'b00000;
                end else if (load_use || ibus_stall_i) begin
                        // Fetch and decode hold and a bubble enters execute.
                        {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = 5'b00011;
                end else begin
                        {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = 5'b11111;
                end
        end

endmodule

// File: design/mips_core.sv
`timescale 1ns/1ps

module mips_core (
        input  logic                clk,
        input  logic                rst_n,
        output mips_isa_pkg::word_t ibus_addr_o,
        input  mips_isa_pkg::word_t ibus_rddata_i,
        input  logic                ibus_stall_i,
        output mips_isa_pkg::word_t dbus_addr_o,
        output logic                dbus_read_o,
        output logic                dbus_write_o,
        output mips_isa_pkg::word_t dbus_wrdata_o,
        input  mips_isa_pkg::word_t dbus_rddata_i,
        input  logic                dbus_stall_i,
        output mips_isa_pkg::word_t pc_o
);
        import mips_isa_pkg::*;
        import mips_pipe_pkg::*;

        logic      en_pc, en_ifid, en_idex, en_exmm, en_mmwb;
        word_t     id_inst, id_pc;
        logic      branch_taken;
        word_t     branch_target;
        reg_addr_t rs_addr, rt_addr;
        word_t     rs_data, rt_data;
        alu_op_t   ex_alu_op;
        mem_op_t   ex_mem_op, mm_mem_op;
        word_t     ex_a, ex_b, ex_store_data, ex_result;
        reg_addr_t ex_dest, mm_dest, wb_dest;
        word_t     mm_addr, mm_store_data, mm_result, wb_result;
        logic      wb_we;

        assign pc_o = ibus_addr_o;

        hazard_ctrl u_hazard (
                .ibus_stall_i(ibus_stall_i), .dbus_stall_i(dbus_stall_i),
                .ex_mem_op_i(ex_mem_op), .ex_dest_i(ex_dest),
                .id_rs_i(rs_addr), .id_rt_i(rt_addr),
                .en_pc_o(en_pc), .en_ifid_o(en_ifid), .en_idex_o(en_idex),
                .en_exmm_o(en_exmm), .en_mmwb_o(en_mmwb));

        fetch_unit u_fetch (
                .clk(clk), .rst_n(rst_n),
                .en_pc_i(en_pc), .en_ifid_i(en_ifid), .en_idex_i(en_idex),
                .branch_taken_i(branch_taken), .branch_target_i(branch_target),
                .ibus_rddata_i(ibus_rddata_i), .pc_o(ibus_addr_o),
                .id_inst_o(id_inst), .id_pc_o(id_pc));

        reg_file u_regs (
                .clk(clk), .rst_n(rst_n),
                .rs_addr_i(rs_addr), .rt_addr_i(rt_addr),
                .rs_data_o(rs_data), .rt_data_o(rt_data),
                .we_i(wb_we), .waddr_i(wb_dest), .wdata_i(wb_result));

        decode_unit u_decode (
                .clk(clk), .rst_n(rst_n), .en_idex_i(en_idex), .en_exmm_i(en_exmm),
                .inst_i(id_inst), .pc_i(id_pc),
                .rs_addr_o(rs_addr), .rt_addr_o(rt_addr),
                .rs_data_i(rs_data), .rt_data_i(rt_data),
                .ex_dest_i(ex_dest), .mm_dest_i(mm_dest), .wb_dest_i(wb_dest),
                .ex_result_i(ex_result), .mm_result_i(mm_result), .wb_result_i(wb_result),
                .wb_we_i(wb_we),
                .branch_taken_o(branch_taken), .branch_target_o(branch_target),
                .ex_alu_op_o(ex_alu_op), .ex_mem_op_o(ex_mem_op),
                .ex_a_o(ex_a), .ex_b_o(ex_b), .ex_store_data_o(ex_store_data),
                .ex_dest_o(ex_dest));

        execute_unit u_execute (
                .clk(clk), .rst_n(rst_n), .en_exmm_i(en_exmm), .en_mmwb_i(en_mmwb),
                .alu_op_i(ex_alu_op), .mem_op_i(ex_mem_op),
                .a_i(ex_a), .b_i(ex_b), .store_data_i(ex_store_data), .dest_i(ex_dest),
                .result_o(ex_result), .mm_addr_o(mm_addr),
                .mm_store_data_o(mm_store_data), .mm_mem_op_o(mm_mem_op),
                .mm_dest_o(mm_dest));

        mem_access u_mem (
                .clk(clk), .rst_n(rst_n), .en_mmwb_i(en_mmwb),
                .addr_i(mm_addr), .store_data_i(mm_store_data),
                .mem_op_i(mm_mem_op), .dest_i(mm_dest), .mm_result_o(mm_result),
                .dbus_addr_o(dbus_addr_o), .dbus_read_o(dbus_read_o),
                .dbus_write_o(dbus_write_o), .dbus_wrdata_o(dbus_wrdata_o),
                .dbus_rddata_i(dbus_rddata_i), .dbus_stall_i(dbus_stall_i),
                .wb_we_o(wb_we), .wb_dest_o(wb_dest), .wb_result_o(wb_result));

endmodule

// File: verif/mips_core_props.sv
`timescale 1ns/1ps

module mips_core_props (
        input logic                clk,
        input logic                rst_n,
        input logic                dbus_stall_i,
        input logic                en_pc_i,
        input logic                en_ifid_i,
        input logic                en_idex_i,
        input logic                en_exmm_i,
        input logic                en_mmwb_i,
        input logic                dbus_read_i,
        input logic                dbus_write_i,
        input mips_isa_pkg::word_t dbus_addr_i,
        input mips_isa_pkg::word_t dbus_wrdata_i
);
        // A data-bus stall freezes every stage.
        stall_drops_enables: assert property (@(posedge clk) disable iff (!rst_n)
                dbus_stall_i |-> !(en_pc_i || en_ifid_i || en_idex_i || en_exmm_i || en_mmwb_i))
                else $error("enable high during a data-bus stall");

        read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
                !(dbus_read_i && dbus_write_i))
                else $error("data-bus read and write high together");

        bus_steady_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
                dbus_stall_i |=> $stable({dbus_read_i, dbus_write_i, dbus_addr_i, dbus_wrdata_i}))
                else $error("data-bus outputs changed during a stall");

endmodule

bind mips_core mips_core_props u_props (
        .clk(clk), .rst_n(rst_n), .dbus_stall_i(dbus_stall_i),
        .en_pc_i(en_pc), .en_ifid_i(en_ifid), .en_idex_i(en_idex),
        .en_exmm_i(en_exmm), .en_mmwb_i(en_mmwb),
        .dbus_read_i(dbus_read_o), .dbus_write_i(dbus_write_o),
        .dbus_addr_i(dbus_addr_o), .dbus_wrdata_i(dbus_wrdata_o));

// File: verif/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;
        import mips_isa_pkg::*;

        localparam int TIMEOUT = 1000;
        localparam logic [31:0] MARKER_ADDR = 32'h100;

        logic  clk;
        logic  rst_n;
        word_t ibus_addr_o, ibus_rddata_i, dbus_addr_o, dbus_wrdata_o, dbus_rddata_i, pc_o;
        logic  ibus_stall_i, dbus_stall_i, dbus_read_o, dbus_write_o;

        word_t imem [0:255];
        word_t dmem [0:255];
        word_t log_addr[$], log_data[$], exp_addr[$], exp_data[$];
        logic  random_stalls;
        int    errors, tests, failing;
        word_t seed_value;

        mips_core uut (
                .clk(clk), .rst_n(rst_n),
                .ibus_addr_o(ibus_addr_o), .ibus_rddata_i(ibus_rddata_i),
                .ibus_stall_i(ibus_stall_i),
                .dbus_addr_o(dbus_addr_o), .dbus_read_o(dbus_read_o),
                .dbus_write_o(dbus_write_o), .dbus_wrdata_o(dbus_wrdata_o),
                .dbus_rddata_i(dbus_rddata_i), .dbus_stall_i(dbus_stall_i),
                .pc_o(pc_o));

        always #5 clk = ~clk;

        // Memory models answer on the falling edge. A store is logged when the
        // coming rising edge will accept it.
        always @(negedge clk) begin
                ibus_stall_i  = random_stalls && ($urandom % 32'd4) == 32'd0;
                dbus_stall_i  = random_stalls && ($urandom % 32'd4) == 32'd0;
                ibus_rddata_i = imem[ibus_addr_o[9:2]];
                dbus_rddata_i = dmem[dbus_addr_o[9:2]];
                if (rst_n && dbus_write_o && !dbus_stall_i) begin
                        log_addr.push_back(dbus_addr_o);
                        log_data.push_back(dbus_wrdata_o);
                end
        end

        function automatic word_t enc_r(input reg_addr_t rs, input reg_addr_t rt,
                                        input reg_addr_t rd, input funct_t fn);
                return {OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
        endfunction

        function automatic word_t enc_i(input opcode_t op, input reg_addr_t rs,
                                        input reg_addr_t rt, input imm_t imm);
                return {op, rs, rt, imm};
        endfunction

        task automatic clear_program();
                for (int i = 0; i < 256; i++) begin
                        imem[i] = 32'h0;
                        dmem[i] = 32'hd00d_0000 ^ (i * 32'h0001_0203);
                end
                log_addr.delete();
                log_data.delete();
                exp_addr.delete();
                exp_data.delete();
        endtask

        // Marker store followed by a branch to itself with a NOP delay slot.
        task automatic add_tail(input int idx);
                imem[idx]     = enc_i(OPC_ORI, 5'd0, 5'd8, 16'hbeef);
                imem[idx + 1] = enc_i(OPC_SW, 5'd0, 5'd8, MARKER_ADDR[15:0]);
                imem[idx + 2] = enc_i(OPC_BEQ, 5'd0, 5'd0, 16'hffff);
                exp_addr.push_back(MARKER_ADDR);
                exp_data.push_back(32'h0000_beef);
        endtask

        task automatic reset_dut();
                rst_n = 1'b0;
                repeat (4) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
        endtask

        task automatic wait_marker(input string name);
                int n;
                for (n = 0; n < TIMEOUT; n++) begin
                        @(posedge clk);
                        if (log_addr.size() > 0 && log_addr[$] == MARKER_ADDR)
                                break;
                end
                if (n == TIMEOUT) begin
                        $display("%s: the marker store never reached the data bus", name);
                        errors++;
                end
        endtask

        task automatic check_log();
                if (log_addr.size() != exp_addr.size()) begin
                        $display("error at %0t: store count = %0d, expected %0d", $time,
                                 log_addr.size(), exp_addr.size());
                        errors++;
                end
                for (int i = 0; i < log_addr.size() && i < exp_addr.size(); i++) begin
                        if (log_addr[i] != exp_addr[i]) begin
                                $display("error at %0t: store %0d dbus_addr_o = %h, expected %h",
                                         $time, i, log_addr[i], exp_addr[i]);
                                errors++;
                        end
                        if (log_data[i] != exp_data[i]) begin
                                $display("error at %0t: store %0d dbus_wrdata_o = %h, expected %h",
                                         $time, i, log_data[i], exp_data[i]);
                                errors++;
                        end
                end
        endtask

        task automatic report(input string name, input int errors_before);
                tests++;
                if (errors == errors_before) begin
                        $display("%s: ok", name);
                end else begin
                        failing++;
                        $display("%s: FAILED", name);
                end
        endtask

        task automatic test_reset();
                int e;
                e = errors;
                clear_program();
                reset_dut();
                #1;
                if (dbus_read_o !== 1'b0) begin
                        $display("error at %0t: dbus_read_o = %b, expected 0", $time, dbus_read_o);
                        errors++;
                end
                if (dbus_write_o !== 1'b0) begin
                        $display("error at %0t: dbus_write_o = %b, expected 0", $time, dbus_write_o);
                        errors++;
                end
                if (ibus_addr_o !== 32'h0) begin
                        $display("error at %0t: ibus_addr_o = %h, expected 0", $time, ibus_addr_o);
                        errors++;
                end
                if (pc_o !== 32'h0) begin
                        $display("error at %0t: pc_o = %h, expected 0", $time, pc_o);
                        errors++;
                end
                report("reset", e);
        endtask

        task automatic test_alu_chain(input string name);
                int    e;
                word_t r [1:7];
                e = errors;
                clear_program();
                imem[0] = enc_i(OPC_ADDIU, 5'd0, 5'd1, 16'h0123);
                imem[1] = enc_i(OPC_ORI, 5'd1, 5'd2, 16'h0f00);
                imem[2] = enc_r(5'd2, 5'd1, 5'd3, FN_ADDU);
                imem[3] = enc_r(5'd3, 5'd1, 5'd4, FN_SUBU);
                imem[4] = enc_r(5'd4, 5'd2, 5'd5, FN_AND);
                imem[5] = enc_r(5'd5, 5'd3, 5'd6, FN_OR);
                imem[6] = enc_r(5'd1, 5'd6, 5'd7, FN_SLT);
                r[1] = 32'h123;
                r[2] = r[1] | 32'h0f00;
                r[3] = r[2] + r[1];
                r[4] = r[3] - r[1];
                r[5] = r[4] & r[2];
                r[6] = r[5] | r[3];
                r[7] = ($signed(r[1]) < $signed(r[6])) ? 32'd1 : 32'd0;
                for (int i = 1; i <= 7; i++) begin
                        imem[6 + i] = enc_i(OPC_SW, 5'd0, i[4:0], 16'(12 + 4 * i));
                        exp_addr.push_back(32'(12 + 4 * i));
                        exp_data.push_back(r[i]);
                end
                add_tail(14);
                reset_dut();
                wait_marker(name);
                check_log();
                report(name, e);
        endtask

        task automatic test_load_use();
                int    e;
                word_t loaded;
                e = errors;
                clear_program();
                loaded = $urandom;
                dmem[16] = loaded;
                imem[0] = enc_i(OPC_ADDIU, 5'd0, 5'd3, 16'h0055);
                imem[1] = enc_i(OPC_LW, 5'd0, 5'd1, 16'h0040);
                imem[2] = enc_r(5'd1, 5'd3, 5'd2, FN_ADDU);
                imem[3] = enc_i(OPC_SW, 5'd0, 5'd2, 16'h0044);
                exp_addr.push_back(32'h44);
                exp_data.push_back(loaded + 32'h55);
                add_tail(4);
                reset_dut();
                wait_marker("load-use");
                check_log();
                report("load-use", e);
        endtask

        // Tags 0x84 and 0x98 sit on skipped paths.
        word_t exp_tags [0:7] = '{32'h80, 32'h88, 32'h8c, 32'h90,
                                  32'h94, 32'h9c, 32'ha0, 32'ha4};

        task automatic test_branches();
                int e;
                e = errors;
                clear_program();
                imem[0] = enc_i(OPC_ADDIU, 5'd0, 5'd1, 16'd5);
                imem[1] = enc_i(OPC_ADDIU, 5'd0, 5'd2, 16'd5);
                imem[2] = enc_i(OPC_ADDIU, 5'd0, 5'd3, 16'd7);
                // Four branches, each with a delay slot, a skip slot and a target.
                imem[3] = enc_i(OPC_BEQ, 5'd1, 5'd2, 16'd2);
                imem[7] = enc_i(OPC_BEQ, 5'd1, 5'd3, 16'd2);
                imem[10] = enc_i(OPC_BNE, 5'd1, 5'd3, 16'd2);
                imem[14] = enc_i(OPC_BNE, 5'd1, 5'd2, 16'd2);
                imem[4] = enc_i(OPC_SW, 5'd0, 5'd1, 16'h80);
                imem[5] = enc_i(OPC_SW, 5'd0, 5'd1, 16'h84);
                imem[6] = enc_i(OPC_SW, 5'd0, 5'd1, 16'h88);
                imem[8] = enc_i(OPC_SW, 5'd0, 5'd1, 16'h8c);
                imem[9] = enc_i(OPC_SW, 5'd0, 5'd1, 16'h90);
                imem[11] = enc_i(OPC_SW, 5'd0, 5'd1, 16'h94);
                imem[12] = enc_i(OPC_SW, 5'd0, 5'd1, 16'h98);
                imem[13] = enc_i(OPC_SW, 5'd0, 5'd1, 16'h9c);
                imem[15] = enc_i(OPC_SW, 5'd0, 5'd1, 16'ha0);
                imem[16] = enc_i(OPC_SW, 5'd0, 5'd1, 16'ha4);
                foreach (exp_tags[i]) begin
                        exp_addr.push_back(exp_tags[i]);
                        exp_data.push_back(32'd5);
                end
                add_tail(17);
                reset_dut();
                wait_marker("branches");
                check_log();
                report("branches", e);
        endtask

        initial begin
                clk           = 1'b0;
                rst_n         = 1'b0;
                ibus_stall_i  = 1'b0;
                dbus_stall_i  = 1'b0;
                ibus_rddata_i = 32'h0;
                dbus_rddata_i = 32'h0;
                random_stalls = 1'b0;
                errors        = 0;
                tests         = 0;
                failing       = 0;
                seed_value    = $urandom(32'h7f0a);
                test_reset();
                test_alu_chain("alu chain");
                test_load_use();
                test_branches();
                random_stalls = 1'b1;
                test_alu_chain("stalls");
                random_stalls = 1'b0;
                $display("summary: %0d tests, %0d failing, %0d errors", tests, failing, errors);
                if (errors == 0) begin
                        $display("Test passed");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule

// File: project.f
design/mips_isa_pkg.sv
design/mips_pipe_pkg.sv
design/reg_file.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/mem_access.sv
design/hazard_ctrl.sv
design/mips_core.sv
verif/mips_core_props.sv
verif/tb_mips_core.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_mips_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf $(BUILD_DIR)
